//--- list.f
+incdir+verilog
+incdir+tests
verilog/audio_pkg.sv
verilog/audio_cfg_regs.sv
verilog/audio_source_mix.sv
verilog/audio_compressor.sv
verilog/audio_out_top.sv
tests/tb_audio_out.sv

//--- run.sh
#!/bin/sh
# Build the audio output testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_audio_out \
	--Mdir obj_dir \
	-o tb_audio_out \
	-f list.f

# A fatal stop returns nonzero, the log decides the verdict
./obj_dir/tb_audio_out > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi

//--- tests/tb_audio_ref.svh
// Reference model of the audio output stage and typed compare tasks, included by the testbench top
`ifndef TB_AUDIO_REF_SVH
`define TB_AUDIO_REF_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// PSG at 1/2 + 1/4 + 1/16
function automatic int psg_atten(input int s);
	return (s >>> 1) + (s >>> 2) + (s >>> 4);
endfunction

// ADPCM at 1/2 + 1/4 + 1/8
function automatic int adpcm_atten(input int s);
	return (s >>> 1) + (s >>> 2) + (s >>> 3);
endfunction

// Sum of enabled sources, times 5/4, top 16 of 18 bits
function automatic int mix_channel(input int psg, input int cdda, input int adpcm,
		input logic psg_on, input logic cdda_on, input logic adpcm_on);
	int sum;
	int scaled;
	sum = 0;
	if (psg_on)
		sum = sum + psg_atten(psg);
	if (cdda_on)
		sum = sum + cdda;
	if (adpcm_on)
		sum = sum + adpcm_atten(adpcm);
	scaled = sum + (sum >>> 2);
	return scaled >>> 2;
endfunction

// Piecewise boost curve on the magnitude
function automatic int boost_curve(input int m, input boost_t mode);
	int v;
	int knee;
	int gain;
	int slope_div;
	int offset;
	int r;
	if (mode == BOOST_OFF)
		return m;
	if (mode == BOOST_4X) begin
		knee      = int'(`COMP_X2);
		gain      = int'(`COMP_A2);
		slope_div = int'(`COMP_F2);
		offset    = int'(`COMP_B2);
	end else begin
		knee      = int'(`COMP_X1);
		gain      = int'(`COMP_A1);
		slope_div = int'(`COMP_F1);
		offset    = int'(`COMP_B1);
	end
	v = (m < 0) ? -m : m;
	if (v < knee)
		r = v * gain;
	else
		r = (v - knee) / slope_div + offset;
	// ~(r - 1) is just the two's complement negate
	return (m < 0) ? -r : r;
endfunction

// Expected {left, right} for one strobe
function automatic logic [31:0] expected_pair(input sample_t p_l, input sample_t p_r,
		input sample_t c_l, input sample_t c_r, input sample_t ad,
		input logic psg_on, input logic cdda_on, input logic adpcm_on, input boost_t mode);
	int left;
	int right;
	left  = mix_channel(int'(p_l), int'(c_l), int'(ad), psg_on, cdda_on, adpcm_on);
	right = mix_channel(int'(p_r), int'(c_r), int'(ad), psg_on, cdda_on, adpcm_on);
	left  = boost_curve(left, mode);
	right = boost_curve(right, mode);
	return {sample_t'(left), sample_t'(right)};
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic abort_run();
	$display("=== FAIL ===");
	$fatal(1, "Simulation stopped at the first error");
endtask

task automatic compare_sample(input string name, input sample_t expected, input sample_t actual);
	if (actual !== expected) begin
		$display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
		abort_run();
	end
endtask

// Catches stray, missing and late strobes
task automatic compare_valid(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("FAILED t=%0t %s expected %b actual %b", $time, name, expected, actual);
		abort_run();
	end
endtask

`endif

//--- tests/tb_audio_out.sv
// Self-checking testbench for the audio output stage, run through run.sh with Verilator
`timescale 1ns/1ps
`include "audio_defines.svh"

module tb_audio_out;

	import audio_pkg::*;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 10;
	localparam int MAX_GAP        = 3;
	localparam int N_RANDOM       = 48;
	localparam int N_BURST        = 20;
	localparam int N_PER_MUTE     = 12;
	localparam int N_ILLEGAL      = 8;
	localparam int N_CURVE_POINTS = 8;
	localparam int N_PHASES       = 12;
	localparam int IDLE_TAIL      = 20;
	localparam int NO_CDDA        = 99999;

	localparam int TOTAL_SAMPLES = N_RANDOM + N_BURST + 3 * N_PER_MUTE + N_ILLEGAL
	                             + 2 * N_CURVE_POINTS;
	localparam int TEST_CYCLES   = RESET_CYCLES + TOTAL_SAMPLES * (2 + MAX_GAP)
	                             + N_PHASES * (`AUDIO_PIPE_LAT + 8) + IDLE_TAIL;
	localparam int WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD + 1000;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       cfg_wr;
	cfg_reg_t   cfg_addr;
	logic [7:0] cfg_data;
	logic       sample_valid;
	sample_t    psg_l;
	sample_t    psg_r;
	sample_t    cdda_l;
	sample_t    cdda_r;
	sample_t    adpcm;
	logic       out_valid;
	sample_t    audio_l;
	sample_t    audio_r;

	// Configuration as the host believes it to be
	boost_t model_boost;
	logic   model_psg_en;
	logic   model_cdda_en;
	logic   model_adpcm_en;

	sample_t exp_l_q[$];
	sample_t exp_r_q[$];
	int      exp_cycle_q[$];
	int      head_idx;
	int      cycle_cnt;
	int      checks_done;

	`include "tb_audio_ref.svh"

	audio_out_top audio_out_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.sample_valid (sample_valid),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.adpcm        (adpcm),
		.out_valid    (out_valid),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#1;
			sample_valid = 1'b0;
			cfg_wr       = 1'b0;
		end
	endtask

	task automatic write_cfg(input cfg_reg_t addr, input logic [7:0] data);
		@(posedge clk_sys);
		#1;
		sample_valid = 1'b0;
		cfg_wr       = 1'b1;
		cfg_addr     = addr;
		cfg_data     = data;
		// Code 3 leaves boost alone
		if (addr == REG_BOOST) begin
			if (data[1:0] != 2'd3)
				model_boost = boost_t'(data[1:0]);
		end else begin
			model_psg_en   = data[0];
			model_cdda_en  = data[1];
			model_adpcm_en = data[2];
		end
		@(posedge clk_sys);
		#1;
		cfg_wr = 1'b0;
	endtask

	// Strobe stays high until the next drive
	task automatic send_sample(input sample_t pl, input sample_t pr, input sample_t cl,
			input sample_t cr, input sample_t ad);
		logic [31:0] pair;
		@(posedge clk_sys);
		#1;
		cfg_wr       = 1'b0;
		sample_valid = 1'b1;
		psg_l        = pl;
		psg_r        = pr;
		cdda_l       = cl;
		cdda_r       = cr;
		adpcm        = ad;
		pair = expected_pair(pl, pr, cl, cr, ad, model_psg_en, model_cdda_en,
			model_adpcm_en, model_boost);
		exp_l_q.push_back(sample_t'(pair[31:16]));
		exp_r_q.push_back(sample_t'(pair[15:0]));
		exp_cycle_q.push_back(cycle_cnt + `AUDIO_PIPE_LAT);
	endtask

	task automatic send_random();
		send_sample(sample_t'($urandom), sample_t'($urandom), sample_t'($urandom),
			sample_t'($urandom), sample_t'($urandom));
	endtask

	task automatic wait_drain();
		while (head_idx < exp_l_q.size()) begin
			@(posedge clk_sys);
			#1;
			sample_valid = 1'b0;
		end
		idle_cycles(2);
	endtask

	task automatic run_muted(input logic [2:0] enables);
		write_cfg(REG_ENABLE, {5'd0, enables});
		repeat (N_PER_MUTE) begin
			send_random();
			idle_cycles(int'($urandom_range(MAX_GAP, 0)));
		end
		wait_drain();
	endtask

	// CD-DA value that lands the mix exactly on a target
	function automatic int find_cdda(input int target, input int base);
		int c;
		for (c = -32768; c <= 32767; c++) begin
			if (mix_channel(base, c, base, 1'b1, 1'b1, 1'b1) == target)
				return c;
		end
		return NO_CDDA;
	endfunction

	// Below, at and above the knee on both signs, then the rails
	task automatic run_curve_points(input boost_t mode, input int knee);
		int targets[6];
		int base;
		int c;
		int i;
		write_cfg(REG_BOOST, {6'd0, mode});
		targets = '{knee - 1, knee, knee + 1, -(knee - 1), -knee, -(knee + 1)};
		for (i = 0; i < 6; i++) begin
			base = (targets[i] < 0) ? -32768 : 32767;
			c = find_cdda(targets[i], base);
			if (c == NO_CDDA) begin
				$display("No CD-DA input reaches mix value %0d", targets[i]);
				abort_run();
			end
			send_sample(sample_t'(base), sample_t'(base), sample_t'(c), sample_t'(c),
				sample_t'(base));
			idle_cycles(1);
		end
		send_sample(16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh7fff);
		send_sample(16'sh8000, 16'sh8000, 16'sh8000, 16'sh8000, 16'sh8000);
		wait_drain();
	endtask

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	// Negedge sampling keeps clear of the output register
	always @(negedge clk_sys) begin : check_outputs
		logic due;
		due = (head_idx < exp_cycle_q.size()) && (exp_cycle_q[head_idx] == cycle_cnt);
		compare_valid("out_valid", due, out_valid);
		if (due) begin
			compare_sample("audio_l", exp_l_q[head_idx], audio_l);
			compare_sample("audio_r", exp_r_q[head_idx], audio_r);
			head_idx    = head_idx + 1;
			checks_done = checks_done + 1;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog ran out after %0d ns before the tests finished", WATCHDOG_NS);
		abort_run();
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		reset          = 1'b1;
		cfg_wr         = 1'b0;
		cfg_addr       = REG_BOOST;
		cfg_data       = 8'd0;
		sample_valid   = 1'b0;
		psg_l          = '0;
		psg_r          = '0;
		cdda_l         = '0;
		cdda_r         = '0;
		adpcm          = '0;
		model_boost    = BOOST_OFF;
		model_psg_en   = 1'b1;
		model_cdda_en  = 1'b1;
		model_adpcm_en = 1'b1;
		head_idx       = 0;
		cycle_cnt      = 0;
		checks_done    = 0;
		void'($urandom(32'hd402_2297));

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		idle_cycles(4);

		// Reset defaults, random gaps
		repeat (N_RANDOM) begin
			send_random();
			idle_cycles(int'($urandom_range(MAX_GAP, 0)));
		end
		wait_drain();

		// Back to back strobes
		repeat (N_BURST) send_random();
		wait_drain();

		// One source muted at a time
		run_muted(3'b110);
		run_muted(3'b101);
		run_muted(3'b011);
		write_cfg(REG_ENABLE, 8'h07);

		run_curve_points(BOOST_2X, int'(`COMP_X1));
		run_curve_points(BOOST_4X, int'(`COMP_X2));

		// Code 3 must keep the 4x curve, a taken code 3 would fall to the 2x curve
		write_cfg(REG_BOOST, {6'd0, BOOST_4X});
		write_cfg(REG_BOOST, 8'h03);
		repeat (N_ILLEGAL) send_random();
		wait_drain();

		// Quiet bus, no strobes expected
		idle_cycles(IDLE_TAIL);

		if (checks_done != TOTAL_SAMPLES) begin
			$display("Checked %0d outputs but %0d samples were sent", checks_done,
				TOTAL_SAMPLES);
			abort_run();
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

//--- verilog/audio_cfg_regs.sv
// Configuration registers for boost mode and source enables, written by the host one word at a time
`timescale 1ns/1ps

module audio_cfg_regs (
	input  logic               clk_sys,
	input  logic               reset,

	// Host write strobe with address and data in the same cycle
	input  logic               cfg_wr,
	input  audio_pkg::cfg_reg_t cfg_addr,
	input  logic [7:0]         cfg_data,

	// Registered levels to the datapath
	output audio_pkg::boost_t  boost,
	output logic               psg_en,
	output logic               cdda_en,
	output logic               adpcm_en
);

	import audio_pkg::*;

	logic boost_code_ok;

	// Code 3 has no curve behind it
	assign boost_code_ok = (cfg_data[1:0] != 2'd3);

	////////////////////////////////////////////////////////////
	// Boost register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boost <= BOOST_OFF;
		end else if (cfg_wr && cfg_addr == REG_BOOST && boost_code_ok) begin
			boost <= boost_t'(cfg_data[1:0]);
		end
	end

	////////////////////////////////////////////////////////////
	// Source enables
	////////////////////////////////////////////////////////////

	// All sources on out of reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			psg_en   <= 1'b1;
			cdda_en  <= 1'b1;
			adpcm_en <= 1'b1;
		end else if (cfg_wr && cfg_addr == REG_ENABLE) begin
			psg_en   <= cfg_data[0];
			cdda_en  <= cfg_data[1];
			adpcm_en <= cfg_data[2];
		end
	end

	// Illegal mode must never reach the compressor
	a_boost_legal: assert property (
		@(posedge clk_sys) disable iff (reset)
		2'(boost) != 2'd3
	) else $error("audio_cfg_regs: boost holds illegal code");

endmodule

//--- verilog/audio_compressor.sv
// Audio boost stage: applies the selected compressor curve to each channel, one cycle of latency
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_compressor (
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              mix_valid,
	input  audio_pkg::sample_t mix_l,
	input  audio_pkg::sample_t mix_r,
	input  audio_pkg::boost_t  boost,

	output logic              out_valid,
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r
);

	import audio_pkg::*;

	// Piecewise curve on the magnitude, sign put back afterwards
	function automatic sample_t compress(input sample_t s, input logic curve2);
		logic [`AUDIO_SAMPLE_W-1:0] v;
		logic [`AUDIO_SAMPLE_W-1:0] v1;
		logic [`AUDIO_SAMPLE_W-1:0] v2;
		logic [`AUDIO_SAMPLE_W-1:0] r;
		v = s[`AUDIO_SAMPLE_W-1] ? (~s) + 16'd1 : s;
		// Linear gain below the knee, shallow slope above it
		v1 = (v < `COMP_X1) ? v * `COMP_A1
		                    : ((v - `COMP_X1) / `COMP_F1) + `COMP_B1;
		v2 = (v < `COMP_X2) ? v * `COMP_A2
		                    : ((v - `COMP_X2) / `COMP_F2) + `COMP_B2;
		r = curve2 ? v2 : v1;
		return s[`AUDIO_SAMPLE_W-1] ? ~(r - 16'd1) : r;
	endfunction

	logic    use_4x;
	sample_t comp_l;
	sample_t comp_r;

	////////////////////////////////////////////////////////////
	// Curve select
	////////////////////////////////////////////////////////////

	assign use_4x = (boost == BOOST_4X);

	always_comb begin
		comp_l = compress(mix_l, use_4x);
		comp_r = compress(mix_r, use_4x);
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= mix_valid;
		end
	end

	// Boost off passes the mix straight through
	always_ff @(posedge clk_sys) begin
		if (boost == BOOST_OFF) begin
			audio_l <= mix_l;
			audio_r <= mix_r;
		end else begin
			audio_l <= comp_l;
			audio_r <= comp_r;
		end
	end

	// Output strobe is the mix strobe one cycle later
	a_valid_follow: assert property (
		@(posedge clk_sys) disable iff (reset)
		out_valid == $past(mix_valid)
	) else $error("audio_compressor: out_valid lost step with mix_valid");

endmodule

//--- verilog/audio_defines.svh
// Sample widths and compressor curve constants, included by the audio package and datapath
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

// One signed audio sample
`define AUDIO_SAMPLE_W 16
// Mix accumulator, two guard bits over a sample
`define AUDIO_MIX_W 18

////////////////////////////////////////////////////////////
// Compressor curves
////////////////////////////////////////////////////////////

// 2x curve, knee / gain below knee / slope divisor / offset
`define COMP_X1 16'd14043
`define COMP_A1 16'd2
`define COMP_F1 16'd4
`define COMP_B1 16'd28086

// 4x curve, same four values
`define COMP_X2 16'd7400
`define COMP_A2 16'd4
`define COMP_F2 16'd8
`define COMP_B2 16'd29600

// Cycles from sample strobe to output strobe
`define AUDIO_PIPE_LAT 4

`endif

//--- verilog/audio_out_top.sv
// Audio output stage top: configuration registers beside the mix and boost pipeline
`timescale 1ns/1ps

module audio_out_top (
	input  logic               clk_sys,
	input  logic               reset,

	// Host configuration write
	input  logic               cfg_wr,
	input  audio_pkg::cfg_reg_t cfg_addr,
	input  logic [7:0]         cfg_data,

	// Source samples
	input  logic               sample_valid,
	input  audio_pkg::sample_t  psg_l,
	input  audio_pkg::sample_t  psg_r,
	input  audio_pkg::sample_t  cdda_l,
	input  audio_pkg::sample_t  cdda_r,
	input  audio_pkg::sample_t  adpcm,

	// Final output, four cycles after the sample strobe
	output logic               out_valid,
	output audio_pkg::sample_t  audio_l,
	output audio_pkg::sample_t  audio_r
);

	import audio_pkg::*;

	boost_t  boost;
	logic    psg_en;
	logic    cdda_en;
	logic    adpcm_en;
	logic    mix_valid;
	sample_t mix_l;
	sample_t mix_r;

	audio_cfg_regs cfg_regs_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.boost    (boost),
		.psg_en   (psg_en),
		.cdda_en  (cdda_en),
		.adpcm_en (adpcm_en)
	);

	// Three cycles
	audio_source_mix source_mix_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_valid (sample_valid),
		.psg_l        (psg_l),
		.psg_r        (psg_r),
		.cdda_l       (cdda_l),
		.cdda_r       (cdda_r),
		.adpcm        (adpcm),
		.psg_en       (psg_en),
		.cdda_en      (cdda_en),
		.adpcm_en     (adpcm_en),
		.mix_valid    (mix_valid),
		.mix_l        (mix_l),
		.mix_r        (mix_r)
	);

	// One cycle
	audio_compressor compressor_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mix_valid (mix_valid),
		.mix_l     (mix_l),
		.mix_r     (mix_r),
		.boost     (boost),
		.out_valid (out_valid),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

endmodule

//--- verilog/audio_pkg.sv
// Shared sample types and enums for the audio output stage, imported by every block
`include "audio_defines.svh"

package audio_pkg;

	////////////////////////////////////////////////////////////
	// Sample types
	////////////////////////////////////////////////////////////

	// Signed sample as produced by each source
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Wider value used while summing sources
	typedef logic signed [`AUDIO_MIX_W-1:0] mix_t;

	////////////////////////////////////////////////////////////
	// Configuration encodings
	////////////////////////////////////////////////////////////

	// Boost mode, code 3 is not a legal mode
	typedef enum logic [1:0] {
		BOOST_OFF = 2'd0,
		BOOST_2X  = 2'd1,
		BOOST_4X  = 2'd2
	} boost_t;

	// Configuration register addresses
	typedef enum logic {
		REG_BOOST  = 1'b0,
		REG_ENABLE = 1'b1
	} cfg_reg_t;

endpackage

//--- verilog/audio_source_mix.sv
// Three-stage source mixer: attenuate, sum enabled sources, then scale by 5/4 to a 16-bit sample
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_source_mix (
	input  logic              clk_sys,
	input  logic              reset,

	// Source samples, valid with the strobe
	input  logic              sample_valid,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t adpcm,

	// Per-source enables, read in the sum stage
	input  logic              psg_en,
	input  logic              cdda_en,
	input  logic              adpcm_en,

	output logic              mix_valid,
	output audio_pkg::sample_t mix_l,
	output audio_pkg::sample_t mix_r
);

	import audio_pkg::*;

	localparam int GUARD_W = `AUDIO_MIX_W - `AUDIO_SAMPLE_W;

	// PSG scaled by 13/16
	function automatic sample_t att_psg(input sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// ADPCM scaled by 7/8
	function automatic sample_t att_adpcm(input sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	// Sign extend into the accumulator
	function automatic mix_t ext(input sample_t s);
		return {{GUARD_W{s[`AUDIO_SAMPLE_W-1]}}, s};
	endfunction

	logic    s1_valid;
	logic    s2_valid;
	sample_t psg_l_att;
	sample_t psg_r_att;
	sample_t adpcm_att;
	sample_t cdda_l_s1;
	sample_t cdda_r_s1;
	mix_t    sum_l;
	mix_t    sum_r;
	mix_t    scaled_l;
	mix_t    scaled_r;

	////////////////////////////////////////////////////////////
	// Valid chain
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			mix_valid <= 1'b0;
		end else begin
			s1_valid  <= sample_valid;
			s2_valid  <= s1_valid;
			mix_valid <= s2_valid;
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	// Sum plus a quarter of itself, 5/4 of the mix
	assign scaled_l = sum_l + (sum_l >>> 2);
	assign scaled_r = sum_r + (sum_r >>> 2);

	always_ff @(posedge clk_sys) begin
		// Stage 1, attenuation
		psg_l_att <= att_psg(psg_l);
		psg_r_att <= att_psg(psg_r);
		adpcm_att <= att_adpcm(adpcm);
		cdda_l_s1 <= cdda_l;
		cdda_r_s1 <= cdda_r;

		// Stage 2, mono ADPCM feeds both sides
		sum_l <= (cdda_en  ? ext(cdda_l_s1) : '0)
		       + (psg_en   ? ext(psg_l_att) : '0)
		       + (adpcm_en ? ext(adpcm_att) : '0);
		sum_r <= (cdda_en  ? ext(cdda_r_s1) : '0)
		       + (psg_en   ? ext(psg_r_att) : '0)
		       + (adpcm_en ? ext(adpcm_att) : '0);

		// Stage 3, keep the top bits
		mix_l <= scaled_l[`AUDIO_MIX_W-1 -: `AUDIO_SAMPLE_W];
		mix_r <= scaled_r[`AUDIO_MIX_W-1 -: `AUDIO_SAMPLE_W];
	end

endmodule
